/* run.sh */
#!/bin/sh
# build and run the afu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_afu_core
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module "$TOP" -Mdir obj_dir -o "$TOP" -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0

/* verification/afu_trace.txt */
// afu_core trace, one 64-bit hex word per line
// @00 hand_ptr, input_base, output_base, batch count, poll entry count
// @10 data seed per batch
// @20 poll entries: bit 17 tag1, bit 16 tag0, bits 15:0 batch size
@00
0000000000001000
0000000000002000
0000000000008000
0000000000000002
0000000000000005
@10
00000000a5c3e117
000000003b9d42f0
@20
// no tag set
0000000000000002
// tag1 only, batch 0 keeps polling
0000000000020004
// tag0, batch 0 with 3 reads
0000000000010003
// tag0 only, batch 1 keeps polling
0000000000010005
// tag1, batch 1 with 4 reads
0000000000020004

/* verification/tb_afu_core.sv */
`default_nettype none

module tb_afu_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 8;
	localparam int TRACE_WORDS = 64;
	localparam int MAX_BATCHES = 16;
	localparam int SEED_BASE = 'h10;
	localparam int POLL_BASE = 'h20;
	localparam int CYCLES_PER_LINE = 2000;
	localparam int WDOG_MARGIN = 5000;

	logic CLK_200M = 1'b0;
	logic reset_n;
	logic core_start;
	logic spl_tx_rd_almostfull;
	logic spl_tx_wr_almostfull;
	logic io_rx_rd_valid;
	logic [afu_pkg::LINE_W-1:0] io_rx_data;
	logic [63:0] io_hand_ptr;
	logic [63:0] io_input_base;
	logic [63:0] io_dst_ptr;
	logic cor_tx_rd_valid;
	logic [afu_pkg::ADDR_W-1:0] cor_tx_rd_addr;
	logic cor_tx_wr_valid;
	logic cor_tx_fence_valid;
	logic [afu_pkg::ADDR_W-1:0] cor_tx_wr_addr;
	logic [afu_pkg::LINE_W-1:0] cor_tx_data;

	logic [63:0] trace_mem [TRACE_WORDS];
	afu_pkg::addr_t hand_addr;
	afu_pkg::addr_t in_addr;
	afu_pkg::addr_t out_addr;
	int num_batches;
	int num_polls;
	int total_lines;
	int wdog_cycles = 0;
	int cur_batch;
	int hand_reads;
	int cycle;
	int edges;
	int wr_seen;
	int af_left;
	int batch_wr_end [MAX_BATCHES];
	logic started;
	logic af_d1;
	logic af_d2;

	afu_pkg::addr_t exp_rd_addr [$];
	afu_pkg::addr_t exp_wr_addr [$];
	afu_pkg::line_t exp_wr_data [$];
	logic exp_wr_fence [$];
	afu_pkg::line_t rsp_line [$];
	int rsp_due [$];

	afu_core u_afu_core (
		.CLK_200M             (CLK_200M),
		.reset_n              (reset_n),
		.core_start           (core_start),
		.spl_tx_rd_almostfull (spl_tx_rd_almostfull),
		.spl_tx_wr_almostfull (spl_tx_wr_almostfull),
		.io_rx_rd_valid       (io_rx_rd_valid),
		.io_rx_data           (io_rx_data),
		.io_hand_ptr          (io_hand_ptr),
		.io_input_base        (io_input_base),
		.io_dst_ptr           (io_dst_ptr),
		.cor_tx_rd_valid      (cor_tx_rd_valid),
		.cor_tx_rd_addr       (cor_tx_rd_addr),
		.cor_tx_wr_valid      (cor_tx_wr_valid),
		.cor_tx_fence_valid   (cor_tx_fence_valid),
		.cor_tx_wr_addr       (cor_tx_wr_addr),
		.cor_tx_data          (cor_tx_data)
	);

	always #CLK_HALF CLK_200M = ~CLK_200M;

	task automatic check_eq(input logic [afu_pkg::LINE_W-1:0] got,
			input logic [afu_pkg::LINE_W-1:0] expected, input string what);
		if (got !== expected) begin
			$display("ERR %0t %s: got %0h, expected %0h", $time, what, got, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// ----------------------------------------------------------
	// trace rules
	// ----------------------------------------------------------

	// every word mixes batch seed, line index and word index
	function automatic afu_pkg::line_t input_line(input logic [31:0] seed, input int idx);
		afu_pkg::line_t line;
		logic [31:0] mix;
		int w;
		line = '0;
		for (w = 0; w < afu_pkg::LINE_W / 32; w++) begin
			mix = seed ^ (32'(idx) * 32'h9e37_79b1) ^ (32'(w) * 32'h85eb_ca6b);
			line[w*32 +: 32] = mix + 32'(idx);
		end
		return line;
	endfunction

	// entry bit 16 is tag0, bit 17 is tag1, low bits the batch size
	function automatic afu_pkg::line_t poll_line(input logic [63:0] entry);
		afu_pkg::line_t line;
		line = '0;
		line[afu_pkg::TAG0_BIT] = entry[16];
		line[afu_pkg::TAG1_BIT] = entry[17];
		line[afu_pkg::BATCH_SIZE_LSB +: afu_pkg::READ_NUM_W + 1] = entry[afu_pkg::READ_NUM_W:0];
		return line;
	endfunction

	task automatic build_expected();
		logic [63:0] entry;
		logic hit;
		int p;
		int b;
		int i;
		int lines;
		afu_pkg::line_t fence;
		afu_pkg::line_t status;
		fence = '0;
		fence[afu_pkg::FENCE_BIT] = 1'b1;
		status = '0;
		status[afu_pkg::LINE_W-1 -: 32] = afu_pkg::STATUS_DONE;
		p = 0;
		total_lines = 0;
		entry = '0;
		for (b = 0; b < num_batches; b++) begin
			// even batches wait for tag0, odd ones for tag1
			hit = 1'b0;
			while (!hit) begin
				if (p >= num_polls) begin
					$display("trace error: no poll entry matches the tag of batch %0d", b);
					$display("Simulation failed");
					$fatal(1, "trace has too few poll entries");
				end
				entry = trace_mem[POLL_BASE + p];
				p++;
				exp_rd_addr.push_back(hand_addr);
				exp_rd_addr.push_back(hand_addr);
				hit = (b % 2 == 0) ? entry[16] : entry[17];
			end
			lines = int'(entry[afu_pkg::READ_NUM_W:0]) * afu_pkg::LINES_PER_READ;
			for (i = 0; i < lines; i++) begin
				exp_rd_addr.push_back(in_addr + afu_pkg::addr_t'(i));
				exp_rd_addr.push_back(in_addr + afu_pkg::addr_t'(i));
				exp_wr_addr.push_back(out_addr + afu_pkg::addr_t'(i));
				exp_wr_data.push_back(input_line(trace_mem[SEED_BASE + b][31:0], i));
				exp_wr_fence.push_back(1'b0);
			end
			exp_wr_addr.push_back('0);
			exp_wr_data.push_back(fence);
			exp_wr_fence.push_back(1'b1);
			exp_wr_addr.push_back(hand_addr);
			exp_wr_data.push_back(status);
			exp_wr_fence.push_back(1'b0);
			exp_wr_addr.push_back('0);
			exp_wr_data.push_back(fence);
			exp_wr_fence.push_back(1'b1);
			total_lines += lines;
			batch_wr_end[b] = exp_wr_addr.size();
		end
	endtask

	// ----------------------------------------------------------
	// memory model, in-order responses after random delays
	// ----------------------------------------------------------
	always @(posedge CLK_200M) begin
		afu_pkg::line_t line;
		int idx;
		cycle++;
		if (cor_tx_rd_valid === 1'b1) begin
			if (cor_tx_rd_addr == hand_addr) begin
				// both reads of a poll pair see the same entry
				idx = hand_reads / 2;
				hand_reads++;
				line = '0;
				if (idx < num_polls) begin
					line = poll_line(trace_mem[POLL_BASE + idx]);
				end
			end else begin
				idx = int'(cor_tx_rd_addr - in_addr);
				line = input_line(trace_mem[SEED_BASE + cur_batch][31:0], idx);
			end
			rsp_line.push_back(line);
			rsp_due.push_back(cycle + 2 + int'($urandom % 6));
		end
		if (rsp_due.size() != 0 && rsp_due[0] <= cycle) begin
			io_rx_rd_valid <= 1'b1;
			io_rx_data     <= rsp_line.pop_front();
			void'(rsp_due.pop_front());
		end else begin
			io_rx_rd_valid <= 1'b0;
		end
	end

	// random almost-full pulses on one of the two levels
	always @(posedge CLK_200M) begin
		if (!reset_n) begin
			af_left = 0;
			spl_tx_rd_almostfull <= 1'b0;
			spl_tx_wr_almostfull <= 1'b0;
		end else if (af_left != 0) begin
			af_left--;
			if (af_left == 0) begin
				spl_tx_rd_almostfull <= 1'b0;
				spl_tx_wr_almostfull <= 1'b0;
			end
		end else if ($urandom % 20 == 0) begin
			af_left = 1 + int'($urandom % 6);
			if ($urandom % 2 == 0) begin
				spl_tx_rd_almostfull <= 1'b1;
			end else begin
				spl_tx_wr_almostfull <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// output monitor
	// ----------------------------------------------------------
	always @(posedge CLK_200M) begin
		edges++;
		if (edges > 1) begin
			if (!started) begin
				check_eq(cor_tx_rd_valid, 1'b0, "read strobe before core_start");
				check_eq(cor_tx_wr_valid, 1'b0, "write strobe before core_start");
			end
			// almost-full seen two edges ago keeps both ports quiet
			if (af_d2) begin
				check_eq(cor_tx_rd_valid, 1'b0, "read strobe under almost-full");
				check_eq(cor_tx_wr_valid, 1'b0, "write strobe under almost-full");
			end
			if (cor_tx_rd_valid) begin
				check_eq(exp_rd_addr.size() != 0, 1'b1, "read with no read expected");
				check_eq(cor_tx_rd_addr, exp_rd_addr.pop_front(), "read address");
			end
			if (cor_tx_wr_valid) begin
				check_eq(exp_wr_addr.size() != 0, 1'b1, "write with no write expected");
				check_eq(cor_tx_wr_addr, exp_wr_addr.pop_front(), "write address");
				check_eq(cor_tx_data, exp_wr_data.pop_front(), "write data");
				check_eq(cor_tx_fence_valid, exp_wr_fence.pop_front(), "fence strobe");
				wr_seen++;
			end else begin
				check_eq(cor_tx_fence_valid, 1'b0, "fence strobe without write strobe");
			end
		end
		af_d2 = af_d1;
		af_d1 = spl_tx_rd_almostfull | spl_tx_wr_almostfull;
	end

	initial begin
		wait (wdog_cycles != 0);
		repeat (wdog_cycles) @(posedge CLK_200M);
		$display("watchdog expired after %0d cycles, the run hung", wdog_cycles);
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

	initial begin
		int b;
		reset_n = 1'b0;
		core_start = 1'b0;
		spl_tx_rd_almostfull = 1'b0;
		spl_tx_wr_almostfull = 1'b0;
		io_rx_rd_valid = 1'b0;
		io_rx_data = '0;
		started = 1'b0;
		cur_batch = 0;
		hand_reads = 0;
		cycle = 0;
		edges = 0;
		wr_seen = 0;
		af_left = 0;
		af_d1 = 1'b0;
		af_d2 = 1'b0;
		void'($urandom(11));

		$readmemh("verification/afu_trace.txt", trace_mem);
		io_hand_ptr = trace_mem[0];
		io_input_base = trace_mem[1];
		io_dst_ptr = trace_mem[2];
		hand_addr = trace_mem[0][afu_pkg::ADDR_W-1:0];
		in_addr = trace_mem[1][afu_pkg::ADDR_W-1:0];
		out_addr = trace_mem[2][afu_pkg::ADDR_W-1:0];
		num_batches = int'(trace_mem[3]);
		num_polls = int'(trace_mem[4]);
		if (num_batches < 1 || num_batches > MAX_BATCHES) begin
			$display("trace error: batch count %0d is out of range", num_batches);
			$display("Simulation failed");
			$fatal(1, "bad trace");
		end
		build_expected();
		wdog_cycles = total_lines * CYCLES_PER_LINE + WDOG_MARGIN;

		repeat (RESET_CYCLES) @(posedge CLK_200M);
		reset_n <= 1'b1;
		repeat (12) @(posedge CLK_200M);

		// one start pulse per batch, next one after the closing fence
		for (b = 0; b < num_batches; b++) begin
			cur_batch <= b;
			started <= 1'b1;
			core_start <= 1'b1;
			@(posedge CLK_200M);
			core_start <= 1'b0;
			while (wr_seen < batch_wr_end[b]) begin
				@(posedge CLK_200M);
			end
		end

		// idle tail, the core stays quiet
		repeat (40) @(posedge CLK_200M);
		check_eq(exp_rd_addr.size(), 0, "reads left over at the end");
		check_eq(exp_wr_addr.size(), 0, "writes left over at the end");
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/afu_core.sv */
`default_nettype none

module afu_core (
	input  wire                        CLK_200M,
	input  wire                        reset_n,
	input  wire                        core_start,

	input  wire                        spl_tx_rd_almostfull,
	input  wire                        spl_tx_wr_almostfull,

	input  wire                        io_rx_rd_valid,
	input  wire [afu_pkg::LINE_W-1:0]  io_rx_data,

	input  wire [63:0]                 io_hand_ptr,
	input  wire [63:0]                 io_input_base,
	input  wire [63:0]                 io_dst_ptr,

	output logic                       cor_tx_rd_valid,
	output logic [afu_pkg::ADDR_W-1:0] cor_tx_rd_addr,

	output logic                       cor_tx_wr_valid,
	output logic                       cor_tx_fence_valid,
	output logic [afu_pkg::ADDR_W-1:0] cor_tx_wr_addr,
	output logic [afu_pkg::LINE_W-1:0] cor_tx_data
);

	afu_pkg::ptr_cfg_t cfg;
	logic stall;
	logic core_start_q;

	afu_pkg::rsp_pair_t pair;
	logic tag0;
	logic tag1;
	logic [afu_pkg::READ_NUM_W:0] batch_size;

	afu_pkg::rd_req_t rd_req;
	logic issue_busy;

	logic capture_data;
	logic wr_cmd_valid;
	afu_pkg::wr_kind_e wr_cmd;
	logic cmd_ready;
	logic line_written;

	// ----------------------------------------------------------
	// input register stage
	// ----------------------------------------------------------

	// line addresses sit in the low ADDR_W bits of each pointer
	always_ff @(posedge CLK_200M) begin
		cfg.hand_ptr    <= io_hand_ptr[afu_pkg::ADDR_W-1:0];
		cfg.input_base  <= io_input_base[afu_pkg::ADDR_W-1:0];
		cfg.output_base <= io_dst_ptr[afu_pkg::ADDR_W-1:0];
	end

	// one cycle of delay on the almost-full levels
	always_ff @(posedge CLK_200M) begin
		stall <= spl_tx_rd_almostfull | spl_tx_wr_almostfull;
	end

	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			core_start_q <= 1'b0;
		end else begin
			core_start_q <= core_start;
		end
	end

	// ----------------------------------------------------------
	// units
	// ----------------------------------------------------------
	rsp_pair_decode u_rsp_pair_decode (
		.CLK_200M       (CLK_200M),
		.reset_n        (reset_n),
		.io_rx_rd_valid (io_rx_rd_valid),
		.io_rx_data     (io_rx_data),
		.pair           (pair),
		.tag0           (tag0),
		.tag1           (tag1),
		.batch_size     (batch_size)
	);

	batch_ctrl u_batch_ctrl (
		.CLK_200M     (CLK_200M),
		.reset_n      (reset_n),
		.core_start   (core_start_q),
		.cfg          (cfg),
		.stall        (stall),
		.pair_valid   (pair.valid),
		.tag0         (tag0),
		.tag1         (tag1),
		.batch_size   (batch_size),
		.issue_busy   (issue_busy),
		.rd_req       (rd_req),
		.line_written (line_written),
		.cmd_ready    (cmd_ready),
		.wr_cmd_valid (wr_cmd_valid),
		.wr_cmd       (wr_cmd),
		.capture_data (capture_data)
	);

	rd_pair_issue u_rd_pair_issue (
		.CLK_200M        (CLK_200M),
		.reset_n         (reset_n),
		.stall           (stall),
		.rd_req          (rd_req),
		.issue_busy      (issue_busy),
		.cor_tx_rd_valid (cor_tx_rd_valid),
		.cor_tx_rd_addr  (cor_tx_rd_addr)
	);

	wr_result u_wr_result (
		.CLK_200M           (CLK_200M),
		.reset_n            (reset_n),
		.stall              (stall),
		.cfg                (cfg),
		.capture_data       (capture_data),
		.pair               (pair),
		.wr_cmd_valid       (wr_cmd_valid),
		.wr_cmd             (wr_cmd),
		.cmd_ready          (cmd_ready),
		.line_written       (line_written),
		.cor_tx_wr_valid    (cor_tx_wr_valid),
		.cor_tx_fence_valid (cor_tx_fence_valid),
		.cor_tx_wr_addr     (cor_tx_wr_addr),
		.cor_tx_data        (cor_tx_data)
	);

endmodule

`default_nettype wire

/* verilog/afu_pkg.sv */
`default_nettype none

package afu_pkg;

	// ----------------------------------------------------------
	// widths and field positions
	// ----------------------------------------------------------
	localparam int ADDR_W = 58;
	localparam int LINE_W = 512;
	localparam int READ_NUM_W = 8;
	// batch size is one bit wider than the read count, times four lines
	localparam int LOAD_PTR_W = READ_NUM_W + 3;
	localparam int LINES_PER_READ = 4;

	// handshake line fields
	localparam int TAG0_BIT = 480;
	localparam int TAG1_BIT = 482;
	localparam int BATCH_SIZE_LSB = 448;

	// write encodings
	localparam int FENCE_BIT = 511;
	localparam logic [31:0] STATUS_DONE = 32'd16;

	// write buffer
	localparam int WR_BUF_DEPTH = 8;
	localparam int BUF_PTR_W = $clog2(WR_BUF_DEPTH);
	localparam int BUF_CNT_W = $clog2(WR_BUF_DEPTH + 1);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [BUF_CNT_W-1:0] buf_cnt_t;

	// ----------------------------------------------------------
	// bundles and opcodes
	// ----------------------------------------------------------
	typedef struct packed {
		logic  valid;
		addr_t addr_1;
		addr_t addr_2;
	} rd_req_t;

	typedef struct packed {
		logic  valid;
		line_t line_k;
		line_t line_l;
	} rsp_pair_t;

	typedef enum logic [1:0] {
		WR_DATA,
		WR_FENCE,
		WR_STATUS
	} wr_kind_e;

	typedef struct packed {
		logic     valid;
		wr_kind_e kind;
		addr_t    addr;
		line_t    data;
	} wr_req_t;

	typedef struct packed {
		addr_t hand_ptr;
		addr_t input_base;
		addr_t output_base;
	} ptr_cfg_t;

	typedef enum logic [2:0] {
		IDLE,
		POLL_REQ,
		POLL_WAIT,
		LOAD,
		DRAIN,
		FENCE_1,
		STATUS,
		FENCE_2
	} batch_state_e;

endpackage

`default_nettype wire

/* verilog/batch_ctrl.sv */
`default_nettype none

module batch_ctrl (
	input  wire                          CLK_200M,
	input  wire                          reset_n,
	input  wire                          core_start,
	input  wire afu_pkg::ptr_cfg_t       cfg,
	input  wire                          stall,
	input  wire                          pair_valid,
	input  wire                          tag0,
	input  wire                          tag1,
	input  wire [afu_pkg::READ_NUM_W:0]  batch_size,
	input  wire                          issue_busy,
	output afu_pkg::rd_req_t             rd_req,
	input  wire                          line_written,
	input  wire                          cmd_ready,
	output logic                         wr_cmd_valid,
	output afu_pkg::wr_kind_e            wr_cmd,
	output logic                         capture_data
);

	typedef logic [afu_pkg::LOAD_PTR_W-1:0] load_ptr_t;

	afu_pkg::batch_state_e state;
	logic polling_tag;
	logic [afu_pkg::READ_NUM_W:0] batch_size_q;
	load_ptr_t load_ptr;
	load_ptr_t cl_num;
	afu_pkg::buf_cnt_t credit;

	logic credit_ok;
	logic tag_match;
	logic rd_accept;
	logic load_issue;

	assign cl_num    = load_ptr_t'(batch_size_q) * load_ptr_t'(afu_pkg::LINES_PER_READ);
	assign credit_ok = credit != afu_pkg::buf_cnt_t'(afu_pkg::WR_BUF_DEPTH);
	assign tag_match = polling_tag ? tag1 : tag0;

	assign rd_accept    = rd_req.valid && !issue_busy;
	assign load_issue   = rd_accept && (state == afu_pkg::LOAD);
	assign capture_data = (state == afu_pkg::LOAD) || (state == afu_pkg::DRAIN);

	// ----------------------------------------------------------
	// read pair requests
	// ----------------------------------------------------------

	// both halves of a pair carry the same address
	always_comb begin
		rd_req = '0;
		if (state == afu_pkg::POLL_REQ) begin
			rd_req.valid  = 1'b1;
			rd_req.addr_1 = cfg.hand_ptr;
			rd_req.addr_2 = cfg.hand_ptr;
		end else if (state == afu_pkg::LOAD && load_ptr != cl_num && credit_ok) begin
			rd_req.valid  = 1'b1;
			rd_req.addr_1 = cfg.input_base + afu_pkg::addr_t'(load_ptr);
			rd_req.addr_2 = cfg.input_base + afu_pkg::addr_t'(load_ptr);
		end
	end

	// ----------------------------------------------------------
	// write commands
	// ----------------------------------------------------------
	always_comb begin
		wr_cmd_valid = 1'b0;
		wr_cmd       = afu_pkg::WR_FENCE;
		case (state)
			afu_pkg::FENCE_1: begin
				wr_cmd_valid = cmd_ready;
			end
			afu_pkg::STATUS: begin
				wr_cmd_valid = cmd_ready;
				wr_cmd       = afu_pkg::WR_STATUS;
			end
			afu_pkg::FENCE_2: begin
				wr_cmd_valid = cmd_ready;
			end
			default: begin
				wr_cmd_valid = 1'b0;
			end
		endcase
	end

	// ----------------------------------------------------------
	// batch FSM
	// ----------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			state       <= afu_pkg::IDLE;
			polling_tag <= 1'b0;
			load_ptr    <= '0;
			credit      <= '0;
		end else begin
			// lines in flight between read issue and write out
			credit <= credit + afu_pkg::buf_cnt_t'(load_issue)
				- afu_pkg::buf_cnt_t'(line_written);

			case (state)
				afu_pkg::IDLE: begin
					if (core_start) begin
						state <= afu_pkg::POLL_REQ;
					end
				end
				afu_pkg::POLL_REQ: begin
					if (rd_accept) begin
						state <= afu_pkg::POLL_WAIT;
					end
				end
				afu_pkg::POLL_WAIT: begin
					if (pair_valid) begin
						if (tag_match) begin
							// tag flips per batch and survives IDLE
							polling_tag <= ~polling_tag;
							load_ptr    <= '0;
							state       <= afu_pkg::LOAD;
						end else begin
							state <= afu_pkg::POLL_REQ;
						end
					end
				end
				afu_pkg::LOAD: begin
					if (load_ptr == cl_num) begin
						state <= afu_pkg::DRAIN;
					end else if (rd_accept) begin
						load_ptr <= load_ptr + 1'b1;
					end
				end
				afu_pkg::DRAIN: begin
					if (credit == '0) begin
						state <= afu_pkg::FENCE_1;
					end
				end
				afu_pkg::FENCE_1: begin
					if (cmd_ready) begin
						state <= afu_pkg::STATUS;
					end
				end
				afu_pkg::STATUS: begin
					if (cmd_ready) begin
						state <= afu_pkg::FENCE_2;
					end
				end
				afu_pkg::FENCE_2: begin
					if (cmd_ready) begin
						state <= afu_pkg::IDLE;
					end
				end
				default: begin
					state <= afu_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (state == afu_pkg::POLL_WAIT && pair_valid && tag_match) begin
			batch_size_q <= batch_size;
		end
	end

	// write buffer room is owed to every read in flight
	a_credit_limit : assert property (
		@(posedge CLK_200M) disable iff (!reset_n)
		rd_accept |-> (credit != afu_pkg::buf_cnt_t'(afu_pkg::WR_BUF_DEPTH))
	);

endmodule

`default_nettype wire

/* verilog/rd_pair_issue.sv */
`default_nettype none

module rd_pair_issue (
	input  wire                        CLK_200M,
	input  wire                        reset_n,
	input  wire                        stall,
	input  wire afu_pkg::rd_req_t      rd_req,
	output logic                       issue_busy,
	output logic                       cor_tx_rd_valid,
	output logic [afu_pkg::ADDR_W-1:0] cor_tx_rd_addr
);

	logic have_1;
	logic have_2;
	logic accept;
	afu_pkg::addr_t addr_1_q;
	afu_pkg::addr_t addr_2_q;

	assign issue_busy = have_1 | have_2;
	assign accept     = rd_req.valid && !issue_busy;

	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			have_1          <= 1'b0;
			have_2          <= 1'b0;
			cor_tx_rd_valid <= 1'b0;
		end else begin
			cor_tx_rd_valid <= 1'b0;
			if (accept) begin
				have_1 <= 1'b1;
				have_2 <= 1'b1;
			end else if (!stall && have_1) begin
				have_1          <= 1'b0;
				cor_tx_rd_valid <= 1'b1;
			end else if (!stall && have_2) begin
				have_2          <= 1'b0;
				cor_tx_rd_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (accept) begin
			addr_1_q <= rd_req.addr_1;
			addr_2_q <= rd_req.addr_2;
		end
		// first half goes out first
		if (!stall && have_1) begin
			cor_tx_rd_addr <= addr_1_q;
		end else if (!stall && have_2) begin
			cor_tx_rd_addr <= addr_2_q;
		end
	end

	// registered stall keeps the read port quiet one cycle later
	a_rd_stall : assert property (
		@(posedge CLK_200M) disable iff (!reset_n)
		stall |=> !cor_tx_rd_valid
	);

endmodule

`default_nettype wire

/* verilog/rsp_pair_decode.sv */
`default_nettype none

module rsp_pair_decode (
	input  wire                          CLK_200M,
	input  wire                          reset_n,
	input  wire                          io_rx_rd_valid,
	input  wire [afu_pkg::LINE_W-1:0]    io_rx_data,
	output afu_pkg::rsp_pair_t           pair,
	output logic                         tag0,
	output logic                         tag1,
	output logic [afu_pkg::READ_NUM_W:0] batch_size
);

	// high when the next beat belongs to the l line
	logic l_next;
	logic pair_valid_q;
	afu_pkg::line_t line_k_q;
	afu_pkg::line_t line_l_q;

	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			l_next       <= 1'b0;
			pair_valid_q <= 1'b0;
		end else begin
			if (io_rx_rd_valid) begin
				l_next <= ~l_next;
			end
			// pair is complete once the l beat is in
			pair_valid_q <= io_rx_rd_valid & l_next;
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (io_rx_rd_valid) begin
			if (l_next) begin
				line_l_q <= io_rx_data;
			end else begin
				line_k_q <= io_rx_data;
			end
		end
	end

	assign pair = '{valid: pair_valid_q, line_k: line_k_q, line_l: line_l_q};

	// handshake fields live in the l line
	assign tag0       = line_l_q[afu_pkg::TAG0_BIT];
	assign tag1       = line_l_q[afu_pkg::TAG1_BIT];
	assign batch_size = line_l_q[afu_pkg::BATCH_SIZE_LSB +: afu_pkg::READ_NUM_W + 1];

	// k and l beats always alternate, so pairs are at least two cycles apart
	a_pair_spacing : assert property (
		@(posedge CLK_200M) disable iff (!reset_n)
		pair.valid |=> !pair.valid
	);

endmodule

`default_nettype wire

/* verilog/wr_result.sv */
`default_nettype none

module wr_result (
	input  wire                        CLK_200M,
	input  wire                        reset_n,
	input  wire                        stall,
	input  wire afu_pkg::ptr_cfg_t     cfg,
	input  wire                        capture_data,
	input  wire afu_pkg::rsp_pair_t    pair,
	input  wire                        wr_cmd_valid,
	input  wire afu_pkg::wr_kind_e     wr_cmd,
	output logic                       cmd_ready,
	output logic                       line_written,
	output logic                       cor_tx_wr_valid,
	output logic                       cor_tx_fence_valid,
	output logic [afu_pkg::ADDR_W-1:0] cor_tx_wr_addr,
	output logic [afu_pkg::LINE_W-1:0] cor_tx_data
);

	afu_pkg::wr_req_t fifo_mem [afu_pkg::WR_BUF_DEPTH];
	logic [afu_pkg::BUF_PTR_W-1:0] wr_ptr;
	logic [afu_pkg::BUF_PTR_W-1:0] rd_ptr;
	afu_pkg::buf_cnt_t count;
	afu_pkg::addr_t line_cnt;

	afu_pkg::wr_req_t push_req;
	afu_pkg::wr_req_t head;
	afu_pkg::line_t fence_line;
	afu_pkg::line_t status_line;
	logic data_push;
	logic push;
	logic pop;

	assign data_push = capture_data && pair.valid;
	assign push      = data_push || wr_cmd_valid;
	assign pop       = !stall && (count != '0);
	assign cmd_ready = count == '0;
	assign head      = fifo_mem[rd_ptr];

	// ----------------------------------------------------------
	// write entry build
	// ----------------------------------------------------------
	always_comb begin
		fence_line = '0;
		fence_line[afu_pkg::FENCE_BIT] = 1'b1;
		status_line = '0;
		status_line[afu_pkg::LINE_W-1 -: 32] = afu_pkg::STATUS_DONE;

		// k line is the copy of the input line
		push_req.valid = push;
		push_req.kind  = afu_pkg::WR_DATA;
		push_req.addr  = cfg.output_base + line_cnt;
		push_req.data  = pair.line_k;
		if (!data_push) begin
			push_req.kind = wr_cmd;
			if (wr_cmd == afu_pkg::WR_STATUS) begin
				push_req.addr = cfg.hand_ptr;
				push_req.data = status_line;
			end else begin
				push_req.addr = '0;
				push_req.data = fence_line;
			end
		end
	end

	// ----------------------------------------------------------
	// buffer control and output strobes
	// ----------------------------------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			wr_ptr             <= '0;
			rd_ptr             <= '0;
			count              <= '0;
			line_cnt           <= '0;
			cor_tx_wr_valid    <= 1'b0;
			cor_tx_fence_valid <= 1'b0;
			line_written       <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + afu_pkg::buf_cnt_t'(push) - afu_pkg::buf_cnt_t'(pop);

			// output line index restarts with each batch
			if (!capture_data) begin
				line_cnt <= '0;
			end else if (data_push) begin
				line_cnt <= line_cnt + 1'b1;
			end

			// fences also raise the write strobe, bit 511 marks them
			cor_tx_wr_valid    <= pop && head.valid;
			cor_tx_fence_valid <= pop && (head.kind == afu_pkg::WR_FENCE);
			line_written       <= pop && (head.kind == afu_pkg::WR_DATA);
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (push) begin
			fifo_mem[wr_ptr] <= push_req;
		end
		if (pop) begin
			cor_tx_wr_addr <= head.addr;
			cor_tx_data    <= head.data;
		end
	end

	// read credit in the batch FSM keeps the buffer from overflowing
	a_no_overflow : assert property (
		@(posedge CLK_200M) disable iff (!reset_n)
		push |-> (count != afu_pkg::buf_cnt_t'(afu_pkg::WR_BUF_DEPTH))
	);

endmodule

`default_nettype wire

/* vlog.f */
verilog/afu_pkg.sv
verilog/rsp_pair_decode.sv
verilog/batch_ctrl.sv
verilog/rd_pair_issue.sv
verilog/wr_result.sv
verilog/afu_core.sv
verification/tb_afu_core.sv
